// File: design/saturnGlue_defs.svh
`ifndef SATURN_GLUE_DEFS_SVH
`define SATURN_GLUE_DEFS_SVH

// Bus widths
`define CPU_ADDR_W 25
`define CPU_DATA_W 32
`define SUB_DATA_W 16
`define CD_ADDR_W  18
`define IDLE_CNT_W 8

// Debug hook target in CS3 space
`define HOOK_ADDR 25'h0012B0

// Read data when no slave answers
`define ABUS_IDLE_DATA 16'hFFFF
`define BBUS_IDLE_DATA 16'h0000

`endif

// File: design/saturnGluePkg.sv
`include "saturnGlue_defs.svh"

package saturnGluePkg;

	typedef logic [`CPU_ADDR_W-1:0] cpuAddrT;
	typedef logic [`CPU_DATA_W-1:0] cpuDataT;
	typedef logic [`SUB_DATA_W-1:0] subDataT;
	typedef logic [`CD_ADDR_W-1:0]  cdAddrT;
	typedef logic [`IDLE_CNT_W-1:0] idleCntT;

	// Main CPU cycle as seen on the SCU side
	typedef struct packed {
		cpuAddrT    addr;
		cpuDataT    wdata;
		logic       rdN;
		logic [3:0] dqmN;   // Byte lanes low on writes
		logic       cs3N;
	} cpuCycleT;

	// DCC memory chip enables
	typedef struct packed {
		logic dramN;
		logic romN;
		logic sramN;
	} memSelT;

	typedef struct packed {
		logic [21:1] addr;   // Halfword address
		subDataT     wdata;
		logic        wrlN;
		logic        wrhN;
		logic        rdN;
		logic        cs1N;   // CD RAM window
	} shBusT;

endpackage

// File: design/cpuBusBridge.sv
`timescale 1ns/1ps

module cpuBusBridge (
	input  saturnGluePkg::cpuCycleT cpuCycle,
	input  saturnGluePkg::memSelT   memSel,
	input  saturnGluePkg::cpuDataT  memRdata,
	input  logic                    memWaitN,
	input  logic [7:0]              smpcRdata,
	input  logic                    smpcSelN,
	input  saturnGluePkg::cpuDataT  scuRdata,
	input  logic                    scuWaitN,

	output saturnGluePkg::cpuAddrT  memAddr,
	output saturnGluePkg::cpuDataT  memWdata,
	output logic [3:0]              memDqmN,
	output logic                    memRdN,
	output logic                    romCsN,
	output logic                    sramCsN,
	output logic                    ramlCsN,
	output logic                    ramhCsN,
	output saturnGluePkg::cpuDataT  cpuRdata,
	output logic                    cpuWaitN
);

	logic memHit;

	// Memory owns the cycle when any of its selects is low
	assign memHit = ~(cpuCycle.cs3N & memSel.dramN & memSel.romN & memSel.sramN);

	assign memAddr  = cpuCycle.addr;
	assign memWdata = cpuCycle.wdata;
	assign memDqmN  = cpuCycle.dqmN;
	assign memRdN   = cpuCycle.rdN;
	assign romCsN   = memSel.romN;
	assign sramCsN  = memSel.sramN;
	assign ramlCsN  = memSel.dramN;
	assign ramhCsN  = cpuCycle.cs3N;   // High work RAM sits on CS3

	assign cpuRdata = memHit    ? memRdata :
	                  !smpcSelN ? {4{smpcRdata}} :   // SMPC answers on every byte lane
	                  scuRdata;

	// Memory wait only counts while memory owns the cycle
	assign cpuWaitN = scuWaitN & (memWaitN | ~memHit);

endmodule

// File: design/subBusReturn.sv
`timescale 1ns/1ps
`include "saturnGlue_defs.svh"

module subBusReturn (
	input  logic                   aCs0N,
	input  logic                   aCs1N,
	input  logic                   aCs2N,
	input  saturnGluePkg::subDataT cartRdata,
	input  saturnGluePkg::subDataT cdRdata,
	input  logic                   cartWaitN,
	input  logic                   cdWaitN,

	input  logic                   bCs1N,
	input  logic                   bCs2N,
	input  logic                   bCssN,
	input  saturnGluePkg::subDataT vdp1Rdata,
	input  saturnGluePkg::subDataT vdp2Rdata,
	input  saturnGluePkg::subDataT scspRdata,

	output saturnGluePkg::subDataT aRdata,
	output logic                   aWaitN,
	output saturnGluePkg::subDataT bRdata
);

	// Cartridge covers A-bus CS0 and CS1 and the CD block answers on CS2
	assign aRdata = (!aCs0N || !aCs1N) ? cartRdata :
	                !aCs2N             ? cdRdata :
	                `ABUS_IDLE_DATA;             // Open bus floats high

	// Either slave can stretch the cycle
	assign aWaitN = cartWaitN & cdWaitN;

	// B-bus in VDP1, VDP2, SCSP order
	assign bRdata = !bCs1N ? vdp1Rdata :
	                !bCs2N ? vdp2Rdata :
	                !bCssN ? scspRdata :
	                `BBUS_IDLE_DATA;

endmodule

// File: design/busActivityMonitor.sv
`timescale 1ns/1ps
`include "saturnGlue_defs.svh"

module busActivityMonitor (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    sysCeR,
	input  saturnGluePkg::cpuCycleT cpuCycle,

	output saturnGluePkg::idleCntT  idleCnt,
	output logic                    hook
);

	logic strobe;
	logic hookHit;

	// Any read or byte write ends an idle stretch
	assign strobe = ~cpuCycle.rdN | ~(&cpuCycle.dqmN);

	assign hookHit = ~cpuCycle.rdN & ~cpuCycle.cs3N & (cpuCycle.addr == `HOOK_ADDR);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			idleCnt <= '0;
		end else if (sysCeR) begin
			if (strobe) begin
				idleCnt <= '0;
			end else begin
				idleCnt <= idleCnt + saturnGluePkg::idleCntT'(1);   // Wraps at top
			end
		end
	end

	// Sticky until reset
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hook <= 1'b0;
		end else if (sysCeR && hookHit) begin
			hook <= 1'b1;
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N) hook |=> hook)
		else $error("hook cleared without reset");

endmodule

// File: design/cdRamBridge.sv
`timescale 1ns/1ps

module cdRamBridge (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   cdCe,
	input  saturnGluePkg::shBusT   shBus,
	input  logic                   dack0,
	input  logic                   dack1,
	input  saturnGluePkg::subDataT ygrRdata,
	input  saturnGluePkg::subDataT cdRamQ,
	input  logic                   cdRamRdy,

	output logic                   shCeR,
	output logic                   shCeF,
	output saturnGluePkg::cdAddrT  cdRamAddr,
	output saturnGluePkg::subDataT cdRamWdata,
	output logic [1:0]             cdRamWe,
	output logic                   cdRamRd,
	output logic                   cdRamCs,
	output saturnGluePkg::subDataT shRdata,
	output logic                   shWaitN
);

	logic phase;

	// SH1 runs at half the CD enable rate
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (cdCe) begin
			phase <= ~phase;
		end
	end

	assign shCeR = phase & cdCe;
	assign shCeF = ~phase & cdCe;   // First after reset

	assign cdRamAddr = shBus.addr[18:1];

	// During DMA the YGR supplies the data
	assign cdRamWdata = (!dack0 || !dack1) ? ygrRdata : shBus.wdata;

	assign cdRamCs = ~shBus.cs1N;
	assign cdRamWe = ~{shBus.wrhN, shBus.wrlN};
	assign cdRamRd = ~shBus.rdN;

	assign shRdata = !shBus.cs1N ? cdRamQ : ygrRdata;
	assign shWaitN = cdRamRdy;

	assert property (@(posedge CLK) disable iff (!RST_N) !(shCeR && shCeF))
		else $error("SH1 rise and fall enables overlap");

endmodule

// File: design/saturnGlue.sv
`timescale 1ns/1ps

module saturnGlue (
	input  logic                     CLK,
	input  logic                     RST_N,

	input  saturnGluePkg::cpuCycleT  cpuCycle,
	input  saturnGluePkg::memSelT    memSel,
	input  saturnGluePkg::cpuDataT   memRdata,
	input  logic                     memWaitN,
	input  logic [7:0]               smpcRdata,
	input  logic                     smpcSelN,
	input  saturnGluePkg::cpuDataT   scuRdata,
	input  logic                     scuWaitN,

	input  logic                     aCs0N,
	input  logic                     aCs1N,
	input  logic                     aCs2N,
	input  saturnGluePkg::subDataT   cartRdata,
	input  saturnGluePkg::subDataT   cdRdata,
	input  logic                     cartWaitN,
	input  logic                     cdWaitN,

	input  logic                     bCs1N,
	input  logic                     bCs2N,
	input  logic                     bCssN,
	input  saturnGluePkg::subDataT   vdp1Rdata,
	input  saturnGluePkg::subDataT   vdp2Rdata,
	input  saturnGluePkg::subDataT   scspRdata,

	input  logic                     sysCeR,
	input  logic                     cdCe,

	input  saturnGluePkg::shBusT     shBus,
	input  logic                     dack0,
	input  logic                     dack1,
	input  saturnGluePkg::subDataT   ygrRdata,
	input  saturnGluePkg::subDataT   cdRamQ,
	input  logic                     cdRamRdy,

	output saturnGluePkg::cpuAddrT   memAddr,
	output saturnGluePkg::cpuDataT   memWdata,
	output logic [3:0]               memDqmN,
	output logic                     memRdN,
	output logic                     romCsN,
	output logic                     sramCsN,
	output logic                     ramlCsN,
	output logic                     ramhCsN,
	output saturnGluePkg::cpuDataT   cpuRdata,
	output logic                     cpuWaitN,

	output saturnGluePkg::subDataT   aRdata,
	output logic                     aWaitN,
	output saturnGluePkg::subDataT   bRdata,

	output saturnGluePkg::idleCntT   idleCnt,
	output logic                     hook,

	output logic                     shCeR,
	output logic                     shCeF,
	output saturnGluePkg::cdAddrT    cdRamAddr,
	output saturnGluePkg::subDataT   cdRamWdata,
	output logic [1:0]               cdRamWe,
	output logic                     cdRamRd,
	output logic                     cdRamCs,
	output saturnGluePkg::subDataT   shRdata,
	output logic                     shWaitN
);

	// Main bus side
	cpuBusBridge u_cpuBusBridge (
		.cpuCycle  (cpuCycle),
		.memSel    (memSel),
		.memRdata  (memRdata),
		.memWaitN  (memWaitN),
		.smpcRdata (smpcRdata),
		.smpcSelN  (smpcSelN),
		.scuRdata  (scuRdata),
		.scuWaitN  (scuWaitN),
		.memAddr   (memAddr),
		.memWdata  (memWdata),
		.memDqmN   (memDqmN),
		.memRdN    (memRdN),
		.romCsN    (romCsN),
		.sramCsN   (sramCsN),
		.ramlCsN   (ramlCsN),
		.ramhCsN   (ramhCsN),
		.cpuRdata  (cpuRdata),
		.cpuWaitN  (cpuWaitN)
	);

	subBusReturn u_subBusReturn (
		.aCs0N     (aCs0N),
		.aCs1N     (aCs1N),
		.aCs2N     (aCs2N),
		.cartRdata (cartRdata),
		.cdRdata   (cdRdata),
		.cartWaitN (cartWaitN),
		.cdWaitN   (cdWaitN),
		.bCs1N     (bCs1N),
		.bCs2N     (bCs2N),
		.bCssN     (bCssN),
		.vdp1Rdata (vdp1Rdata),
		.vdp2Rdata (vdp2Rdata),
		.scspRdata (scspRdata),
		.aRdata    (aRdata),
		.aWaitN    (aWaitN),
		.bRdata    (bRdata)
	);

	busActivityMonitor u_busActivityMonitor (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.sysCeR   (sysCeR),
		.cpuCycle (cpuCycle),
		.idleCnt  (idleCnt),
		.hook     (hook)
	);

	// CD block side
	cdRamBridge u_cdRamBridge (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cdCe       (cdCe),
		.shBus      (shBus),
		.dack0      (dack0),
		.dack1      (dack1),
		.ygrRdata   (ygrRdata),
		.cdRamQ     (cdRamQ),
		.cdRamRdy   (cdRamRdy),
		.shCeR      (shCeR),
		.shCeF      (shCeF),
		.cdRamAddr  (cdRamAddr),
		.cdRamWdata (cdRamWdata),
		.cdRamWe    (cdRamWe),
		.cdRamRd    (cdRamRd),
		.cdRamCs    (cdRamCs),
		.shRdata    (shRdata),
		.shWaitN    (shWaitN)
	);

endmodule

// File: tb/saturnGlueChecker.sv
`timescale 1ns/1ps
`include "saturnGlue_defs.svh"

module saturnGlueChecker (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  saturnGluePkg::cpuCycleT cpuCycle,
	input  saturnGluePkg::memSelT   memSel,
	input  saturnGluePkg::shBusT    shBus,
	input  saturnGluePkg::cpuDataT  memRdata, scuRdata, memWdata, cpuRdata,
	input  saturnGluePkg::cpuAddrT  memAddr,
	input  logic [7:0]              smpcRdata,
	input  logic [3:0]              memDqmN,
	input  saturnGluePkg::subDataT  cartRdata, cdRdata, vdp1Rdata, vdp2Rdata, scspRdata,
	input  saturnGluePkg::subDataT  ygrRdata, cdRamQ, aRdata, bRdata, cdRamWdata, shRdata,
	input  saturnGluePkg::cdAddrT   cdRamAddr,
	input  saturnGluePkg::idleCntT  idleCnt,
	input  logic [1:0]              cdRamWe,
	input  logic                    memWaitN, smpcSelN, scuWaitN, cartWaitN, cdWaitN,
	input  logic                    aCs0N, aCs1N, aCs2N, bCs1N, bCs2N, bCssN,
	input  logic                    sysCeR, cdCe, dack0, dack1, cdRamRdy, expHook,
	input  logic                    memRdN, romCsN, sramCsN, ramlCsN, ramhCsN, cpuWaitN,
	input  logic                    aWaitN, hook, shCeR, shCeF, cdRamRd, cdRamCs, shWaitN,
	output int                      errCount,
	output int                      checkCount
);

	saturnGluePkg::idleCntT idleModel;
	logic hookModel;
	logic phaseModel;
	int errors = 0;
	int checks = 0;

	assign errCount   = errors;
	assign checkCount = checks;

	task automatic expectEqual(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at time %0t: %s is %0h, expected %0h",
				$time, what, got, exp);
		end
	endtask

	// Reference state for counter, hook and SH1 phase
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			idleModel  <= '0;
			hookModel  <= 1'b0;
			phaseModel <= 1'b0;
		end else begin
			if (sysCeR) begin
				idleModel <= (!cpuCycle.rdN || cpuCycle.dqmN != 4'hF) ? '0 : idleModel + 8'd1;
			end
			if (sysCeR && !cpuCycle.rdN && !cpuCycle.cs3N && cpuCycle.addr == `HOOK_ADDR) begin
				hookModel <= 1'b1;
			end
			if (cdCe) begin
				phaseModel <= !phaseModel;
			end
		end
	end

	// Sampled mid-cycle after the inputs settle
	always @(negedge CLK) begin : checkOutputs
		logic memHit;
		saturnGluePkg::cpuDataT expCpu;
		saturnGluePkg::subDataT expA;
		saturnGluePkg::subDataT expB;
		if (RST_N) begin
			memHit = !(cpuCycle.cs3N && memSel.dramN && memSel.romN && memSel.sramN);
			if (memHit) expCpu = memRdata;
			else if (!smpcSelN) expCpu = {smpcRdata, smpcRdata, smpcRdata, smpcRdata};
			else expCpu = scuRdata;
			if (!aCs0N || !aCs1N) expA = cartRdata;
			else if (!aCs2N) expA = cdRdata;
			else expA = `ABUS_IDLE_DATA;
			if (!bCs1N) expB = vdp1Rdata;
			else if (!bCs2N) expB = vdp2Rdata;
			else if (!bCssN) expB = scspRdata;
			else expB = `BBUS_IDLE_DATA;

			expectEqual("memAddr", 64'(memAddr), 64'(cpuCycle.addr));
			expectEqual("memWdata", 64'(memWdata), 64'(cpuCycle.wdata));
			expectEqual("memory strobes", 64'({memDqmN, memRdN}),
				64'({cpuCycle.dqmN, cpuCycle.rdN}));
			expectEqual("memory chip selects", 64'({romCsN, sramCsN, ramlCsN, ramhCsN}),
				64'({memSel.romN, memSel.sramN, memSel.dramN, cpuCycle.cs3N}));
			expectEqual("cpuRdata", 64'(cpuRdata), 64'(expCpu));
			expectEqual("cpuWaitN", 64'(cpuWaitN), 64'(scuWaitN && (memWaitN || !memHit)));
			expectEqual("aRdata", 64'(aRdata), 64'(expA));
			expectEqual("aWaitN", 64'(aWaitN), 64'(cartWaitN && cdWaitN));
			expectEqual("bRdata", 64'(bRdata), 64'(expB));
			expectEqual("idleCnt", 64'(idleCnt), 64'(idleModel));
			expectEqual("hook", 64'(hook), 64'(hookModel));
			expectEqual("hook against table", 64'(hook), 64'(expHook));
			expectEqual("SH1 enables", 64'({shCeR, shCeF}),
				64'({phaseModel && cdCe, !phaseModel && cdCe}));
			expectEqual("cdRamAddr", 64'(cdRamAddr), 64'(shBus.addr[18:1]));
			expectEqual("cdRamWdata", 64'(cdRamWdata),
				64'((!dack0 || !dack1) ? ygrRdata : shBus.wdata));
			expectEqual("CD RAM strobes", 64'({cdRamCs, cdRamRd, cdRamWe}),
				64'({!shBus.cs1N, !shBus.rdN, !shBus.wrhN, !shBus.wrlN}));
			expectEqual("shRdata", 64'(shRdata), 64'(shBus.cs1N ? ygrRdata : cdRamQ));
			expectEqual("shWaitN", 64'(shWaitN), 64'(cdRamRdy));
		end
	end

endmodule

// File: tb/saturnGlueTb.sv
`timescale 1ns/1ps
`include "saturnGlue_defs.svh"

module saturnGlueTb;

	typedef struct packed {
		logic [8:0] reps;      // Cycles the row is held
		logic [5:0] cpu;
		logic [3:0] dqmN;
		logic [5:0] sub;
		logic [1:0] ce;
		logic [5:0] sh;
		logic [1:0] addrSel;
		logic       expHook;   // Hook level while the row is applied
	} rowT;

	localparam int NROWS = 24;

	logic CLK = 1'b0;
	logic RST_N;
	saturnGluePkg::cpuCycleT cpuCycle;
	saturnGluePkg::memSelT memSel;
	saturnGluePkg::shBusT shBus;
	saturnGluePkg::cpuDataT memRdata, scuRdata, memWdata, cpuRdata;
	saturnGluePkg::cpuAddrT memAddr;
	logic [7:0] smpcRdata;
	logic [3:0] memDqmN;
	saturnGluePkg::subDataT cartRdata, cdRdata, vdp1Rdata, vdp2Rdata, scspRdata;
	saturnGluePkg::subDataT ygrRdata, cdRamQ, aRdata, bRdata, cdRamWdata, shRdata;
	saturnGluePkg::cdAddrT cdRamAddr;
	saturnGluePkg::idleCntT idleCnt;
	logic [1:0] cdRamWe;
	logic memWaitN, smpcSelN, scuWaitN, cartWaitN, cdWaitN;
	logic aCs0N, aCs1N, aCs2N, bCs1N, bCs2N, bCssN;
	logic sysCeR, cdCe, dack0, dack1, cdRamRdy, expHook;
	logic memRdN, romCsN, sramCsN, ramlCsN, ramhCsN, cpuWaitN;
	logic aWaitN, hook, shCeR, shCeF, cdRamRd, cdRamCs, shWaitN;
	int errCount, checkCount;

	rowT rows [NROWS];
	logic [31:0] lfsr = 32'hce21_7787;
	int cycles = 0;
	int limit = 0;

	saturnGlue u_saturnGlue (.*);
	saturnGlueChecker u_checker (.*);

	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic applyRow(input rowT r);
		logic [31:0] w;
		{memSel.dramN, memSel.romN, memSel.sramN, cpuCycle.cs3N, smpcSelN, cpuCycle.rdN} = r.cpu;
		cpuCycle.dqmN = r.dqmN;
		{aCs0N, aCs1N, aCs2N, bCs1N, bCs2N, bCssN} = r.sub;
		{sysCeR, cdCe} = r.ce;
		{shBus.cs1N, shBus.rdN, shBus.wrhN, shBus.wrlN, dack0, dack1} = r.sh;
		expHook = r.expHook;
		takeBits(30, w);
		cpuCycle.addr = w[24:0];
		{memWaitN, scuWaitN, cartWaitN, cdWaitN, cdRamRdy} = w[29:25];
		case (r.addrSel)
			2'd1: cpuCycle.addr = `HOOK_ADDR;
			2'd2: cpuCycle.addr = `HOOK_ADDR ^ 25'h1;         // Near miss on the low bit
			2'd3: cpuCycle.addr = `HOOK_ADDR ^ 25'h100_0000;  // Near miss on the top bit
			default: ;
		endcase
		takeBits(32, w);
		cpuCycle.wdata = w;
		takeBits(32, w);
		memRdata = w;
		takeBits(32, w);
		scuRdata = w;
		takeBits(32, w);
		{cartRdata, cdRdata} = w;
		takeBits(32, w);
		{vdp1Rdata, vdp2Rdata} = w;
		takeBits(32, w);
		{scspRdata, ygrRdata} = w;
		takeBits(32, w);
		{cdRamQ, shBus.wdata} = w;
		takeBits(29, w);
		{smpcRdata, shBus.addr} = w[28:0];
	endtask

	initial begin
		int total;
		RST_N = 1'b0;
		// reps, cpu {dramN romN sramN cs3N smpcSelN rdN}, dqmN, sub {aCs0-2 bCs1 bCs2 bCss},
		// ce {sysCeR cdCe}, sh {cs1N rdN wrhN wrlN dack0 dack1}, address select, hook
		rows[0]  = '{9'd4,   6'b111111, 4'hF, 6'b111111, 2'b00, 6'b111111, 2'd0, 1'b0};
		rows[1]  = '{9'd4,   6'b111101, 4'hF, 6'b111110, 2'b10, 6'b111111, 2'd0, 1'b0};
		rows[2]  = '{9'd4,   6'b011101, 4'hF, 6'b110101, 2'b10, 6'b011111, 2'd0, 1'b0};
		rows[3]  = '{9'd4,   6'b101111, 4'hF, 6'b101011, 2'b01, 6'b101111, 2'd0, 1'b0};
		rows[4]  = '{9'd4,   6'b110101, 4'hE, 6'b011000, 2'b01, 6'b110111, 2'd0, 1'b0};
		rows[5]  = '{9'd4,   6'b111000, 4'hF, 6'b001001, 2'b11, 6'b001010, 2'd0, 1'b0};
		rows[6]  = '{9'd4,   6'b000111, 4'h0, 6'b111100, 2'b11, 6'b110100, 2'd0, 1'b0};
		rows[7]  = '{9'd3,   6'b111111, 4'hF, 6'b111111, 2'b01, 6'b111101, 2'd0, 1'b0};
		rows[8]  = '{9'd300, 6'b111111, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd0, 1'b0};
		rows[9]  = '{9'd5,   6'b111111, 4'hF, 6'b111111, 2'b00, 6'b111111, 2'd0, 1'b0};
		rows[10] = '{9'd3,   6'b111111, 4'h7, 6'b111111, 2'b10, 6'b111111, 2'd0, 1'b0};
		rows[11] = '{9'd20,  6'b111111, 4'hF, 6'b111111, 2'b11, 6'b111111, 2'd0, 1'b0};
		rows[12] = '{9'd2,   6'b111111, 4'hB, 6'b111111, 2'b10, 6'b111111, 2'd0, 1'b0};
		rows[13] = '{9'd10,  6'b111111, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd0, 1'b0};
		rows[14] = '{9'd1,   6'b111110, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd1, 1'b0};
		rows[15] = '{9'd2,   6'b111010, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd2, 1'b0};
		rows[16] = '{9'd2,   6'b111010, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd3, 1'b0};
		rows[17] = '{9'd2,   6'b111110, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd1, 1'b0};
		rows[18] = '{9'd2,   6'b111011, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd1, 1'b0};
		rows[19] = '{9'd2,   6'b111010, 4'hF, 6'b111111, 2'b00, 6'b111111, 2'd1, 1'b0};
		rows[20] = '{9'd1,   6'b111010, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd1, 1'b0};
		rows[21] = '{9'd6,   6'b011101, 4'hF, 6'b110011, 2'b11, 6'b000011, 2'd0, 1'b1};
		rows[22] = '{9'd4,   6'b111010, 4'hF, 6'b111111, 2'b10, 6'b111111, 2'd2, 1'b1};
		rows[23] = '{9'd40,  6'b111111, 4'hF, 6'b111111, 2'b11, 6'b111111, 2'd0, 1'b1};
		total = 0;
		for (int i = 0; i < NROWS; i++) begin
			total += int'(rows[i].reps);
		end
		limit = total + 16 + 50;   // Reset, table and some slack

		applyRow(rows[0]);
		repeat (16) @(posedge CLK);
		#1 RST_N = 1'b1;
		for (int i = 0; i < NROWS; i++) begin
			for (int k = 0; k < int'(rows[i].reps); k++) begin
				@(posedge CLK);
				#1;
				applyRow(rows[i]);
			end
		end
		@(posedge CLK);

		$display("Checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0 && checkCount > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+design
design/saturnGluePkg.sv
design/cpuBusBridge.sv
design/subBusReturn.sv
design/busActivityMonitor.sv
design/cdRamBridge.sv
design/saturnGlue.sv
tb/saturnGlueChecker.sv
tb/saturnGlueTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the saturnGlue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f list.f --top-module saturnGlueTb -o saturnGlueSim

if ./obj_dir/saturnGlueSim | tee /dev/stderr | grep -x "SIMULATION PASSED" > /dev/null; then
	echo "run.sh: testbench reported success"
else
	echo "run.sh: testbench did not report success"
	exit 1
fi
